// ==== hw/uoramPkg.sv ====
package uoramPkg;

    // ==================================================================
    // sizes
    // ==================================================================
    localparam int dataWidth     = 32;
    localparam int addrWidth     = 7;
    localparam int leafWidth     = 7;
    localparam int leafInBlock   = 4;
    localparam int numValidBlock = 64;
    localparam int level2Base    = 80;
    localparam int recursion     = 3;
    localparam int plbEntries    = 4;

    // one position entry is {init flag, leaf}
    localparam int entryWidth   = dataWidth / leafInBlock;
    localparam int slotWidth    = $clog2(leafInBlock);
    localparam int plbIdxWidth  = $clog2(plbEntries);
    localparam int numRootBlock = 4;

    // ==================================================================
    // commands and payloads
    // ==================================================================
    typedef logic [dataWidth-1:0] dataWordT;

    typedef struct packed {
        logic                 isWrite;
        logic [addrWidth-1:0] addr;
    } progCmdT;

    typedef enum logic [1:0] {beRead, beWrite, beReadRmv, beAppend} beCmdE;

    typedef struct packed {
        beCmdE                cmd;
        logic [addrWidth-1:0] addr;
        logic [leafWidth-1:0] oldLeaf;
        logic [leafWidth-1:0] newLeaf;
    } beCmdT;

    typedef enum logic [1:0] {plbLookup, plbRefill, plbInitRefill} plbCmdE;

    typedef struct packed {
        logic                 hit;
        logic                 uninit;
        logic [leafWidth-1:0] oldLeaf;
        logic [leafWidth-1:0] newLeaf;
        logic                 evict;
        logic [addrWidth-1:0] evictAddr;
        logic [leafWidth-1:0] evictLeaf;
    } plbResultT;

    typedef enum logic [2:0] {
        progToStore,
        loadToReturn,
        loadToRefill,
        evictToStore,
        zeroToReturnAndStore
    } routeE;

    // position-map block that holds the leaf of a
    function automatic logic [addrWidth-1:0] parentOf(input logic [addrWidth-1:0] a);
        return addrWidth'(numValidBlock + a / leafInBlock);
    endfunction

endpackage

// ==== hw/frontFifo.sv ====
`timescale 1ns/1ps

module frontFifo import uoramPkg::*; #(
    parameter type payloadT = dataWordT
) (
    input  logic    Clock,
    input  logic    rstN,
    input  payloadT inData,
    input  logic    inValid,
    output logic    inReady,
    output payloadT outData,
    output logic    outValid,
    input  logic    outReady
);

    payloadT head, tail;
    logic    headValid, tailValid;
    logic    push, pop;

    // tail only fills when head is already taken
    assign inReady  = !tailValid;
    assign outValid = headValid;
    assign outData  = head;
    assign push     = inValid && inReady;
    assign pop      = headValid && outReady;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            headValid <= 1'b0;
            tailValid <= 1'b0;
        end else if (pop) begin
            headValid <= tailValid || push;
            tailValid <= 1'b0;
        end else if (push) begin
            headValid <= 1'b1;
            tailValid <= headValid;
        end
    end

    always_ff @(posedge Clock) begin
        if (pop) begin
            head <= tailValid ? tail : inData;
        end else if (push && !headValid) begin
            head <= inData;
        end
        if (push && headValid && !pop) begin
            tail <= inData;
        end
    end

endmodule

// ==== hw/posMapBuffer.sv ====
`timescale 1ns/1ps

module posMapBuffer import uoramPkg::*; (
    input  logic                 Clock,
    input  logic                 rstN,
    input  plbCmdE               cmd,
    input  logic                 cmdValid,
    output logic                 cmdReady,
    input  logic [addrWidth-1:0] addr,
    input  dataWordT             refillData,
    output plbResultT            result,
    output logic                 resultValid,
    input  logic                 resultReady,
    output dataWordT             evictData
);

    // direct-mapped lines, indexed by the low bits of the block address
    logic [plbEntries-1:0] lineValid;
    logic [addrWidth-1:0]  lineTag  [plbEntries];
    logic [leafWidth-1:0]  lineLeaf [plbEntries];
    dataWordT              lineData [plbEntries];

    // level-2 leaves never leave the chip
    logic [entryWidth-1:0] rootTable [numRootBlock];

    logic [leafWidth-1:0]            lfsr;
    logic [leafWidth-1:0]            lastNewLeaf;
    logic                            accept, isRoot, lookupHit;
    logic [addrWidth-1:0]            parent, rootOff;
    logic [$clog2(numRootBlock)-1:0] rootIdx;
    logic [plbIdxWidth-1:0]          lookupIdx, refillIdx;
    logic [slotWidth-1:0]            slot;
    logic [entryWidth-1:0]           entry;

    assign cmdReady  = !resultValid;
    assign accept    = cmdValid && cmdReady;
    assign isRoot    = addr >= addrWidth'(level2Base);
    assign parent    = parentOf(addr);
    assign rootOff   = addr - addrWidth'(level2Base);
    assign rootIdx   = rootOff[$clog2(numRootBlock)-1:0];
    assign lookupIdx = parent[plbIdxWidth-1:0];
    assign refillIdx = addr[plbIdxWidth-1:0];
    assign slot      = addr[slotWidth-1:0];
    assign lookupHit = isRoot || (lineValid[lookupIdx] && lineTag[lookupIdx] == parent);
    assign entry     = isRoot ? rootTable[rootIdx]
                              : lineData[lookupIdx][slot*entryWidth +: entryWidth];

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            lineValid   <= '0;
            lfsr        <= leafWidth'(1);
            for (int i = 0; i < numRootBlock; i++) begin
                rootTable[i] <= '0;
            end
        end else begin
            // x^7 + x^6 + 1, free running
            lfsr <= {lfsr[leafWidth-2:0], lfsr[leafWidth-1] ^ lfsr[leafWidth-2]};
            if (accept) begin
                resultValid <= 1'b1;
            end else if (resultReady) begin
                resultValid <= 1'b0;
            end
            if (accept && cmd != plbLookup) begin
                lineValid[refillIdx] <= 1'b1;
            end
            if (accept && cmd == plbLookup && isRoot) begin
                rootTable[rootIdx] <= {1'b1, lfsr};
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (accept && cmd == plbLookup) begin
            result.hit     <= lookupHit;
            result.uninit  <= !entry[entryWidth-1];
            result.oldLeaf <= entry[leafWidth-1:0];
            result.newLeaf <= lfsr;
            result.evict   <= 1'b0;
            lastNewLeaf    <= lfsr;
            // remap in place, the block goes back to the new leaf
            if (lookupHit && !isRoot) begin
                lineData[lookupIdx][slot*entryWidth +: entryWidth] <= {1'b1, lfsr};
            end
        end else if (accept) begin
            result.hit       <= 1'b1;
            result.evict     <= lineValid[refillIdx];
            result.evictAddr <= lineTag[refillIdx];
            result.evictLeaf <= lineLeaf[refillIdx];
            evictData        <= lineData[refillIdx];
            // new line keeps the leaf it was given by the lookup before
            lineTag[refillIdx]  <= addr;
            lineLeaf[refillIdx] <= lastNewLeaf;
            lineData[refillIdx] <= (cmd == plbInitRefill) ? '0 : refillData;
        end
    end

endmodule

// ==== hw/dataScheduler.sv ====
`timescale 1ns/1ps

module dataScheduler import uoramPkg::*; (
    input  logic     Clock,
    input  logic     rstN,
    input  routeE    route,
    input  logic     routeValid,
    output logic     routeDone,
    input  dataWordT progData,
    input  logic     progDataValid,
    output logic     progDataReady,
    output dataWordT returnData,
    output logic     returnDataValid,
    input  logic     returnDataReady,
    output dataWordT storeData,
    output logic     storeDataValid,
    input  logic     storeDataReady,
    input  dataWordT loadData,
    input  logic     loadDataValid,
    output logic     loadDataReady,
    output dataWordT refillData,
    output logic     refillValid,
    input  dataWordT evictData
);

    routeE curRoute;
    logic  active, retSent, stoSent;
    logic  retFire, stoFire, loadFire;

    // open only the path of the current route
    always_comb begin
        returnDataValid = 1'b0;
        storeDataValid  = 1'b0;
        loadDataReady   = 1'b0;
        progDataReady   = 1'b0;
        returnData      = loadData;
        storeData       = progData;
        if (active) begin
            case (curRoute)
                progToStore: begin
                    storeDataValid = progDataValid;
                    progDataReady  = storeDataReady;
                end
                loadToReturn: begin
                    returnDataValid = loadDataValid;
                    loadDataReady   = returnDataReady;
                end
                loadToRefill: loadDataReady = 1'b1;
                evictToStore: begin
                    storeDataValid = 1'b1;
                    storeData      = evictData;
                end
                default: begin
                    returnDataValid = !retSent;
                    storeDataValid  = !stoSent;
                    returnData      = '0;
                    storeData       = '0;
                end
            endcase
        end
    end

    assign retFire  = returnDataValid && returnDataReady;
    assign stoFire  = storeDataValid && storeDataReady;
    assign loadFire = loadDataValid && loadDataReady;

    // zero route needs both sides, in either order
    assign routeDone = active && ((curRoute == zeroToReturnAndStore)
                     ? ((retFire || retSent) && (stoFire || stoSent))
                     : (retFire || stoFire || loadFire));

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            active      <= 1'b0;
            curRoute    <= progToStore;
            retSent     <= 1'b0;
            stoSent     <= 1'b0;
            refillValid <= 1'b0;
        end else if (routeValid) begin
            active      <= 1'b1;
            curRoute    <= route;
            retSent     <= 1'b0;
            stoSent     <= 1'b0;
            refillValid <= 1'b0;
        end else begin
            if (routeDone) begin
                active <= 1'b0;
            end
            if (retFire) begin
                retSent <= 1'b1;
            end
            if (stoFire) begin
                stoSent <= 1'b1;
            end
            if (curRoute == loadToRefill && loadFire) begin
                refillValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (curRoute == loadToRefill && loadFire) begin
            refillData <= loadData;
        end
    end

endmodule

// ==== hw/frontendController.sv ====
`timescale 1ns/1ps

module frontendController import uoramPkg::*; (
    input  logic                 Clock,
    input  logic                 rstN,
    input  progCmdT              progCmd,
    input  logic                 progCmdValid,
    output logic                 progCmdReady,
    output plbCmdE               plbCmd,
    output logic                 plbCmdValid,
    input  logic                 plbCmdReady,
    output logic [addrWidth-1:0] plbAddr,
    input  plbResultT            plbResult,
    input  logic                 plbResultValid,
    output logic                 plbResultReady,
    output routeE                route,
    output logic                 routeValid,
    input  logic                 routeDone,
    input  logic                 refillValid,
    output beCmdT                beCmd,
    output logic                 beCmdValid,
    input  logic                 beCmdReady
);

    typedef enum logic [2:0] {
        sIdle,
        sLookup,
        sLookupRes,
        sBeCmd,
        sRouteWait,
        sRefill,
        sRefillRes
    } stateE;

    stateE                        state;
    progCmdT                      curCmd;
    logic [addrWidth-1:0]         addrQ [recursion];
    logic [$clog2(recursion)-1:0] depth;
    beCmdT                        beCmdReg;
    routeE                        nextRoute;
    plbCmdE                       refillCmd;

    // ==================================================================
    // handshakes, all decoded from the state
    // ==================================================================
    assign progCmdReady   = state == sIdle;
    assign plbCmdValid    = (state == sLookup)
                         || (state == sRefill && (refillCmd == plbInitRefill || refillValid));
    assign plbCmd         = (state == sRefill) ? refillCmd : plbLookup;
    assign plbAddr        = addrQ[depth];
    assign plbResultReady = state == sLookupRes || state == sRefillRes;
    assign beCmdValid     = state == sBeCmd;
    assign beCmd          = beCmdReg;
    // each backend command opens its data route as it goes out
    assign routeValid     = beCmdValid && beCmdReady;
    assign route          = nextRoute;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state <= sIdle;
            depth <= '0;
        end else begin
            case (state)
                sIdle: if (progCmdValid) begin
                    depth <= '0;
                    state <= sLookup;
                end
                sLookup: if (plbCmdReady) begin
                    state <= sLookupRes;
                end
                sLookupRes: if (plbResultValid) begin
                    if (!plbResult.hit) begin
                        depth <= depth + 1'b1;
                        state <= sLookup;
                    end else if (depth != '0 && plbResult.uninit) begin
                        state <= sRefill;
                    end else begin
                        state <= sBeCmd;
                    end
                end
                sBeCmd: if (beCmdReady) begin
                    state <= sRouteWait;
                end
                sRouteWait: if (routeDone) begin
                    if (nextRoute == loadToRefill) begin
                        state <= sRefill;
                    end else if (nextRoute == evictToStore) begin
                        depth <= depth - 1'b1;
                        state <= sLookup;
                    end else begin
                        state <= sIdle;
                    end
                end
                sRefill: if (plbCmdValid && plbCmdReady) begin
                    state <= sRefillRes;
                end
                default: if (plbResultValid) begin
                    if (plbResult.evict) begin
                        state <= sBeCmd;
                    end else begin
                        depth <= depth - 1'b1;
                        state <= sLookup;
                    end
                end
            endcase
        end
    end

    // ==================================================================
    // queue and backend command payloads
    // ==================================================================
    always_ff @(posedge Clock) begin
        if (state == sIdle && progCmdValid) begin
            curCmd   <= progCmd;
            addrQ[0] <= progCmd.addr;
        end
        if (state == sLookupRes && plbResultValid) begin
            // miss, go one level up the position map
            if (!plbResult.hit) begin
                addrQ[depth + 1'b1] <= parentOf(addrQ[depth]);
            end
            beCmdReg.addr    <= addrQ[depth];
            beCmdReg.oldLeaf <= plbResult.oldLeaf;
            beCmdReg.newLeaf <= plbResult.newLeaf;
            refillCmd        <= plbResult.uninit ? plbInitRefill : plbRefill;
            if (depth != '0) begin
                beCmdReg.cmd <= beReadRmv;
                nextRoute    <= loadToRefill;
            end else if (plbResult.uninit) begin
                // first touch of a data block
                beCmdReg.cmd <= beAppend;
                nextRoute    <= curCmd.isWrite ? progToStore : zeroToReturnAndStore;
            end else begin
                beCmdReg.cmd <= curCmd.isWrite ? beWrite : beRead;
                nextRoute    <= curCmd.isWrite ? progToStore : loadToReturn;
            end
        end
        if (state == sRefillRes && plbResultValid) begin
            beCmdReg.cmd     <= beAppend;
            beCmdReg.addr    <= plbResult.evictAddr;
            beCmdReg.oldLeaf <= '0;
            beCmdReg.newLeaf <= plbResult.evictLeaf;
            nextRoute        <= evictToStore;
        end
    end

endmodule

// ==== hw/uoramFrontend.sv ====
`timescale 1ns/1ps

module uoramFrontend import uoramPkg::*; (
    input  logic     Clock,
    input  logic     rstN,
    input  progCmdT  progCmd,
    input  logic     progCmdValid,
    output logic     progCmdReady,
    input  dataWordT progData,
    input  logic     progDataValid,
    output logic     progDataReady,
    output dataWordT returnData,
    output logic     returnDataValid,
    input  logic     returnDataReady,
    output beCmdT    beCmd,
    output logic     beCmdValid,
    input  logic     beCmdReady,
    output dataWordT storeData,
    output logic     storeDataValid,
    input  logic     storeDataReady,
    input  dataWordT loadData,
    input  logic     loadDataValid,
    output logic     loadDataReady
);

    progCmdT              cmdQ;
    logic                 cmdQValid, cmdQReady;
    dataWordT             dataQ;
    logic                 dataQValid, dataQReady;
    plbCmdE               plbCmd;
    logic                 plbCmdValid, plbCmdReady;
    logic [addrWidth-1:0] plbAddr;
    plbResultT            plbResult;
    logic                 plbResultValid, plbResultReady;
    routeE                route;
    logic                 routeValid, routeDone;
    dataWordT             refillData, evictData;
    logic                 refillValid;

    // ==================================================================
    // program side buffers, data may lead or trail its command
    // ==================================================================
    frontFifo #(.payloadT(progCmdT)) cmdFifo (
        .Clock, .rstN,
        .inData(progCmd), .inValid(progCmdValid), .inReady(progCmdReady),
        .outData(cmdQ), .outValid(cmdQValid), .outReady(cmdQReady)
    );

    frontFifo #(.payloadT(dataWordT)) dataFifo (
        .Clock, .rstN,
        .inData(progData), .inValid(progDataValid), .inReady(progDataReady),
        .outData(dataQ), .outValid(dataQValid), .outReady(dataQReady)
    );

    posMapBuffer plb (
        .Clock, .rstN,
        .cmd(plbCmd), .cmdValid(plbCmdValid), .cmdReady(plbCmdReady), .addr(plbAddr),
        .refillData, .result(plbResult), .resultValid(plbResultValid),
        .resultReady(plbResultReady), .evictData
    );

    dataScheduler scheduler (
        .*,
        .progData(dataQ), .progDataValid(dataQValid), .progDataReady(dataQReady)
    );

    frontendController controller (
        .*,
        .progCmd(cmdQ), .progCmdValid(cmdQValid), .progCmdReady(cmdQReady)
    );

endmodule

// ==== tests/uoramFrontend_asserts.sv ====
`timescale 1ns/1ps

module uoramFrontend_asserts import uoramPkg::*; (
    input logic                         Clock,
    input logic                         rstN,
    input beCmdT                        beCmd,
    input logic                         beCmdValid,
    input logic                         beCmdReady,
    input plbCmdE                       plbCmd,
    input logic                         plbCmdValid,
    input logic                         plbCmdReady,
    input logic [addrWidth-1:0]         plbAddr,
    input logic [$clog2(recursion)-1:0] depth
);

    int failures = 0;

    // a backend command that is not taken stays put
    beCmdHold: assert property (@(posedge Clock) disable iff (!rstN)
        beCmdValid && !beCmdReady |=> beCmdValid && $stable(beCmd))
        else begin
            failures++;
            $error("beCmd changed or dropped before its transfer");
        end

    plbCmdHold: assert property (@(posedge Clock) disable iff (!rstN)
        plbCmdValid && !plbCmdReady |=> plbCmdValid && $stable(plbCmd) && $stable(plbAddr))
        else begin
            failures++;
            $error("buffer command changed or dropped before it was accepted");
        end

    // one queue level per position-map level
    depthBound: assert property (@(posedge Clock) disable iff (!rstN) depth < recursion)
        else begin
            failures++;
            $error("recursion queue depth out of range");
        end

endmodule

bind frontendController uoramFrontend_asserts ctrlChecks (
    .Clock(Clock),
    .rstN(rstN),
    .beCmd(beCmd),
    .beCmdValid(beCmdValid),
    .beCmdReady(beCmdReady),
    .plbCmd(plbCmd),
    .plbCmdValid(plbCmdValid),
    .plbCmdReady(plbCmdReady),
    .plbAddr(plbAddr),
    .depth(depth)
);

// ==== tests/uoramFrontend_tb.sv ====
`timescale 1ns/1ps

module uoramFrontend_tb import uoramPkg::*; ();

    localparam int numCommands = 300;
    localparam int waitLimit   = 2000;
    localparam int numAddr     = 1 << addrWidth;

    typedef struct packed {
        logic [addrWidth-1:0] addr;
        dataWordT             data;
        logic                 checked;
    } storeExpT;

    logic     Clock;
    logic     rstN;
    progCmdT  progCmd;
    logic     progCmdValid;
    logic     progCmdReady;
    dataWordT progData;
    logic     progDataValid;
    logic     progDataReady;
    dataWordT returnData;
    logic     returnDataValid;
    logic     returnDataReady = 1'b0;
    beCmdT    beCmd;
    logic     beCmdValid;
    logic     beCmdReady = 1'b0;
    dataWordT storeData;
    logic     storeDataValid;
    logic     storeDataReady = 1'b0;
    dataWordT loadData = '0;
    logic     loadDataValid = 1'b0;
    logic     loadDataReady;

    // backend model, one word and one placed leaf per block address
    dataWordT             beMem       [numAddr];
    logic [leafWidth-1:0] beLeaf      [numAddr];
    logic                 bePresent   [numAddr];
    logic                 beRemoved   [numAddr];
    logic [leafWidth-1:0] removedLeaf [numAddr];

    // program view of the data blocks
    dataWordT progMem [numValidBlock];

    dataWordT loadQ   [$];
    dataWordT returnQ [$];
    storeExpT storeQ  [$];

    int                   seed = 2;
    int                   issued;
    int                   dataCmdCount;
    int                   lastRmvLevel;
    logic                 curWrite;
    logic [addrWidth-1:0] curAddr;
    dataWordT             curData;

    uoramFrontend dut_i (.*);

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    // ==================================================================
    // error reporting and reference rules
    // ==================================================================
    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input dataWordT expected,
                              input dataWordT actual);
        if (expected !== actual) begin
            stopOnError($sformatf("FAIL %0t %s expected %0h actual %0h",
                                  $time, name, expected, actual));
        end
    endtask

    // block that holds the position entry of a
    function automatic logic [addrWidth-1:0] parentBlock(input logic [addrWidth-1:0] a);
        return addrWidth'(numValidBlock) + a / addrWidth'(leafInBlock);
    endfunction

    function automatic logic [addrWidth-1:0] ancestorAt(input logic [addrWidth-1:0] a,
                                                        input int lvl);
        logic [addrWidth-1:0] b;
        b = a;
        for (int i = 0; i < lvl; i++) begin
            b = parentBlock(b);
        end
        return b;
    endfunction

    function automatic int levelOf(input logic [addrWidth-1:0] a);
        if (a >= addrWidth'(level2Base)) begin
            return 2;
        end
        if (a >= addrWidth'(numValidBlock)) begin
            return 1;
        end
        return 0;
    endfunction

    // ==================================================================
    // backend model
    // ==================================================================
    task automatic acceptBeCmd(input beCmdT c);
        int       lvl;
        storeExpT s;
        beCmdE    expCmd;
        lvl = levelOf(c.addr);
        if (dataCmdCount != issued - 1) begin
            stopOnError("backend command seen outside of a program access");
        end
        if (lvl != 0) begin
            if (c.cmd == beReadRmv) begin
                checkValue("beCmd.addr", dataWidth'(ancestorAt(curAddr, lvl)),
                           dataWidth'(c.addr));
                if (lvl >= lastRmvLevel) begin
                    stopOnError("position-map fetches did not start at the deepest level");
                end
                if (!bePresent[c.addr]) begin
                    stopOnError("beReadRmv of a block that the backend does not hold");
                end
                checkValue("beCmd.oldLeaf", dataWidth'(beLeaf[c.addr]), dataWidth'(c.oldLeaf));
                bePresent[c.addr]   = 1'b0;
                beRemoved[c.addr]   = 1'b1;
                removedLeaf[c.addr] = c.newLeaf;
                lastRmvLevel        = lvl;
                loadQ.push_back(beMem[c.addr]);
            end else if (c.cmd == beAppend) begin
                if (bePresent[c.addr]) begin
                    stopOnError("beAppend of a position-map block the backend already holds");
                end
                // a block that came from the backend goes back to its new leaf
                if (beRemoved[c.addr]) begin
                    checkValue("beCmd.newLeaf", dataWidth'(removedLeaf[c.addr]),
                               dataWidth'(c.newLeaf));
                end
                beRemoved[c.addr] = 1'b0;
                bePresent[c.addr] = 1'b1;
                beLeaf[c.addr]    = c.newLeaf;
                s.addr    = c.addr;
                s.data    = '0;
                s.checked = 1'b0;
                storeQ.push_back(s);
            end else begin
                stopOnError("data block command sent for a position-map block");
            end
        end else begin
            checkValue("beCmd.addr", dataWidth'(curAddr), dataWidth'(c.addr));
            if (!bePresent[c.addr]) begin
                expCmd = beAppend;
            end else if (curWrite) begin
                expCmd = beWrite;
            end else begin
                expCmd = beRead;
            end
            checkValue("beCmd.cmd", dataWidth'(expCmd), dataWidth'(c.cmd));
            if (bePresent[c.addr]) begin
                checkValue("beCmd.oldLeaf", dataWidth'(beLeaf[c.addr]), dataWidth'(c.oldLeaf));
            end
            bePresent[c.addr] = 1'b1;
            beLeaf[c.addr]    = c.newLeaf;
            s.addr    = c.addr;
            s.checked = 1'b1;
            if (expCmd == beRead) begin
                loadQ.push_back(beMem[c.addr]);
                returnQ.push_back(curData);
            end else if (curWrite) begin
                s.data = curData;
                storeQ.push_back(s);
            end else begin
                // first read of a block returns and stores zero
                returnQ.push_back(curData);
                s.data = '0;
                storeQ.push_back(s);
            end
            dataCmdCount++;
            lastRmvLevel = 3;
        end
    endtask

    always @(posedge Clock) begin
        int       r;
        storeExpT s;
        if (!rstN) begin
            beCmdReady      <= 1'b0;
            storeDataReady  <= 1'b0;
            returnDataReady <= 1'b0;
            loadDataValid   <= 1'b0;
            dataCmdCount = 0;
            lastRmvLevel = 3;
            for (int a = 0; a < numAddr; a++) begin
                beMem[a]     = '0;
                beLeaf[a]    = '0;
                bePresent[a] = 1'b0;
                beRemoved[a] = 1'b0;
            end
        end else begin
            r = $random(seed);
            if (beCmdValid && beCmdReady) begin
                acceptBeCmd(beCmd);
            end
            if (returnDataValid && returnDataReady) begin
                if (returnQ.size() == 0) begin
                    stopOnError("returnData transfer with no read waiting for it");
                end else begin
                    checkValue("returnData", returnQ[0], returnData);
                    returnQ.delete(0);
                end
            end
            if (storeDataValid && storeDataReady) begin
                if (storeQ.size() == 0) begin
                    stopOnError("storeData transfer with no backend command waiting for it");
                end else begin
                    s = storeQ[0];
                    storeQ.delete(0);
                    if (s.checked) begin
                        checkValue("storeData", s.data, storeData);
                    end
                    beMem[s.addr] = storeData;
                end
            end
            if (loadDataValid && loadDataReady) begin
                loadQ.delete(0);
                loadDataValid <= 1'b0;
            end else if (!loadDataValid && loadQ.size() != 0 && r[3]) begin
                loadData      <= loadQ[0];
                loadDataValid <= 1'b1;
            end
            beCmdReady      <= r[0];
            storeDataReady  <= r[1];
            returnDataReady <= r[2];
        end
    end

    // ==================================================================
    // program side
    // ==================================================================
    task automatic sendCmd(input progCmdT c);
        int cycles;
        @(posedge Clock);
        progCmd      <= c;
        progCmdValid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge Clock);
            cycles++;
            if (cycles > waitLimit) begin
                stopOnError("timeout waiting for progCmdReady");
            end
        end while (!progCmdReady);
        progCmdValid <= 1'b0;
    endtask

    task automatic sendData(input dataWordT d);
        int cycles;
        @(posedge Clock);
        progData      <= d;
        progDataValid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge Clock);
            cycles++;
            if (cycles > waitLimit) begin
                stopOnError("timeout waiting for progDataReady");
            end
        end while (!progDataReady);
        progDataValid <= 1'b0;
    endtask

    task automatic runAccess();
        int      r;
        int      cycles;
        progCmdT c;
        @(negedge Clock);
        r = $random(seed);
        c.isWrite = r[0];
        c.addr    = addrWidth'(r[13:8]);
        curWrite  = c.isWrite;
        curAddr   = c.addr;
        if (c.isWrite) begin
            curData = $random(seed);
            progMem[c.addr] = curData;
        end else begin
            curData = progMem[c.addr];
        end
        issued++;
        // write data may lead or trail its command
        if (c.isWrite && r[1]) begin
            sendData(curData);
            sendCmd(c);
        end else begin
            sendCmd(c);
            if (c.isWrite) begin
                sendData(curData);
            end
        end
        @(negedge Clock);
        cycles = 0;
        while (!(dataCmdCount == issued && returnQ.size() == 0 && storeQ.size() == 0
                 && loadQ.size() == 0)) begin
            @(negedge Clock);
            cycles++;
            if (cycles > waitLimit) begin
                stopOnError("timeout waiting for the program access to finish");
            end
        end
    endtask

    initial begin
        progCmd       = '0;
        progCmdValid  = 1'b0;
        progData      = '0;
        progDataValid = 1'b0;
        rstN          = 1'b0;
        issued        = 0;
        for (int a = 0; a < numValidBlock; a++) begin
            progMem[a] = '0;
        end
        repeat (16) @(posedge Clock);
        rstN <= 1'b1;
        for (int i = 0; i < numCommands; i++) begin
            runAccess();
        end
        @(negedge Clock);
        if (dut_i.controller.ctrlChecks.failures == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stopOnError("controller assertions failed during the run");
        end
    end

endmodule

// ==== uoramFrontend.f ====
hw/uoramPkg.sv
hw/frontFifo.sv
hw/posMapBuffer.sv
hw/dataScheduler.sv
hw/frontendController.sv
hw/uoramFrontend.sv
tests/uoramFrontend_asserts.sv
tests/uoramFrontend_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = uoramFrontend_tb
FILELIST  = uoramFrontend.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)
